// ==== verilog/issue_pkg.sv ====
`default_nettype none

package issue_pkg;

    // issue queue geometry
    localparam int IQ_SIZE  = 8;
    localparam int IQ_IDX_W = 3;
    localparam int IQ_CNT_W = 4;

    // physical register file
    localparam int PREG_NUM = 64;
    localparam int PREG_W   = 6;
    localparam int XLEN     = 32;

    localparam int ROB_W    = 5;

    typedef logic [PREG_W-1:0] preg_t;
    typedef logic [XLEN-1:0]   word_t;
    typedef logic [ROB_W-1:0]  rob_t;

    // port 1 takes alu1 and branch, port 2 takes alu2 and special
    typedef enum logic [1:0] {
        op_alu1,
        op_branch,
        op_alu2,
        op_sp
    } iq_op_e;

endpackage

`default_nettype wire

// ==== verilog/phys_regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

module phys_regfile
    import issue_pkg::*;
(
    input  logic  clk,
    input  preg_t rd_addr1,
    input  preg_t rd_addr2,
    input  preg_t rd_addr3,
    input  preg_t rd_addr4,
    output word_t rd_data1,
    output word_t rd_data2,
    output word_t rd_data3,
    output word_t rd_data4,
    input  logic  wr_en1,
    input  logic  wr_en2,
    input  preg_t wr_addr1,
    input  preg_t wr_addr2,
    input  word_t wr_data1,
    input  word_t wr_data2
);

    word_t regs [PREG_NUM];

    // port 2 is written last so it wins an address clash
    always_ff @(posedge clk) begin
        if (wr_en1) begin
            regs[wr_addr1] <= wr_data1;
        end
        if (wr_en2) begin
            regs[wr_addr2] <= wr_data2;
        end
    end

    // p0 is hardwired zero
    assign rd_data1 = (rd_addr1 == '0) ? '0 : regs[rd_addr1];
    assign rd_data2 = (rd_addr2 == '0) ? '0 : regs[rd_addr2];
    assign rd_data3 = (rd_addr3 == '0) ? '0 : regs[rd_addr3];
    assign rd_data4 = (rd_addr4 == '0) ? '0 : regs[rd_addr4];

endmodule

`default_nettype wire

// ==== verilog/issue_queue.sv ====
`timescale 1ns/10ps
`default_nettype none

module issue_queue
    import issue_pkg::*;
(
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      flush,
    input  logic                      disp1_valid,
    input  iq_op_e                    disp1_op,
    input  word_t                     disp1_pc,
    input  rob_t                      disp1_rob,
    input  preg_t                     disp1_src1,
    input  preg_t                     disp1_src2,
    input  preg_t                     disp1_dest,
    input  logic                      disp1_rf_we,
    input  logic                      disp1_src1_ready,
    input  logic                      disp1_src2_ready,
    input  logic                      disp2_valid,
    input  iq_op_e                    disp2_op,
    input  word_t                     disp2_pc,
    input  rob_t                      disp2_rob,
    input  preg_t                     disp2_src1,
    input  preg_t                     disp2_src2,
    input  preg_t                     disp2_dest,
    input  logic                      disp2_rf_we,
    input  logic                      disp2_src1_ready,
    input  logic                      disp2_src2_ready,
    output logic                      allowin,
    input  logic                      sel1_valid,
    input  logic                      sel2_valid,
    input  logic [IQ_IDX_W-1:0]       sel1_idx,
    input  logic [IQ_IDX_W-1:0]       sel2_idx,
    input  preg_t                     sel1_claim,
    input  preg_t                     sel2_claim,
    input  logic                      iss1_valid,
    input  logic                      iss2_valid,
    input  logic                      iss1_rf_we,
    input  logic                      iss2_rf_we,
    input  iq_op_e                    iss1_op,
    input  iq_op_e                    iss2_op,
    input  preg_t                     iss1_dest,
    input  preg_t                     iss2_dest,
    input  logic                      wb1_we,
    input  logic                      wb2_we,
    input  preg_t                     wb1_dest,
    input  preg_t                     wb2_dest,
    output logic [IQ_SIZE-1:0]        ent_valid,
    output logic [IQ_SIZE-1:0]        ent_src_ready,
    output iq_op_e [IQ_SIZE-1:0]      ent_op,
    output preg_t [IQ_SIZE-1:0]       ent_dest,
    output logic [IQ_SIZE-1:0]        ent_rf_we,
    output word_t                     pick1_pc,
    output rob_t                      pick1_rob,
    output iq_op_e                    pick1_op,
    output preg_t                     pick1_dest,
    output logic                      pick1_rf_we,
    output preg_t                     pick1_src1,
    output preg_t                     pick1_src2,
    output word_t                     pick2_pc,
    output rob_t                      pick2_rob,
    output iq_op_e                    pick2_op,
    output preg_t                     pick2_dest,
    output logic                      pick2_rf_we,
    output preg_t                     pick2_src1,
    output preg_t                     pick2_src2
);

    logic [IQ_SIZE-1:0]               q_valid, n_valid;
    logic [IQ_SIZE-1:0]               q_rdy1, n_rdy1;
    logic [IQ_SIZE-1:0]               q_rdy2, n_rdy2;
    logic [IQ_SIZE-1:0]               q_rf_we, n_rf_we;
    iq_op_e [IQ_SIZE-1:0]             q_op, n_op;
    word_t [IQ_SIZE-1:0]              q_pc, n_pc;
    rob_t [IQ_SIZE-1:0]               q_rob, n_rob;
    preg_t [IQ_SIZE-1:0]              q_src1, n_src1;
    preg_t [IQ_SIZE-1:0]              q_src2, n_src2;
    preg_t [IQ_SIZE-1:0]              q_dest, n_dest;
    logic [IQ_CNT_W-1:0]              q_cnt, n_cnt;

    logic [IQ_SIZE-1:0]               keep;
    logic [IQ_SIZE-1:0][IQ_IDX_W-1:0] dst;
    logic [IQ_SIZE-1:0]               wake1, wake2;
    logic [5:0]                       wk_en;
    preg_t [5:0]                      wk_dest;

    // room for two more, so decode never splits a pair
    assign allowin = q_cnt < IQ_CNT_W'(IQ_SIZE - 1);

    // wakeup sources: select claims, issue register, writeback
    assign wk_en = {wb2_we, wb1_we,
                    iss2_valid && iss2_rf_we && iss2_op != op_sp,
                    iss1_valid && iss1_rf_we && iss1_op != op_sp,
                    sel2_claim != '0, sel1_claim != '0};
    assign wk_dest = {wb2_dest, wb1_dest, iss2_dest, iss1_dest, sel2_claim, sel1_claim};

    always_comb begin
        int gap;
        gap = 0;
        for (int j = 0; j < IQ_SIZE; j++) begin
            keep[j] = q_valid[j]
                   && !(sel1_valid && sel1_idx == IQ_IDX_W'(j))
                   && !(sel2_valid && sel2_idx == IQ_IDX_W'(j));
            // slide down past the selected entries below
            dst[j] = IQ_IDX_W'(j - gap);
            if (q_valid[j] && !keep[j]) begin
                gap++;
            end
            wake1[j] = 1'b0;
            wake2[j] = 1'b0;
            for (int k = 0; k < 6; k++) begin
                wake1[j] |= wk_en[k] && wk_dest[k] == q_src1[j];
                wake2[j] |= wk_en[k] && wk_dest[k] == q_src2[j];
            end
        end
    end

    always_comb begin
        logic [IQ_CNT_W-1:0] tail;
        n_valid = '0;
        n_rdy1  = q_rdy1;
        n_rdy2  = q_rdy2;
        n_rf_we = q_rf_we;
        n_op    = q_op;
        n_pc    = q_pc;
        n_rob   = q_rob;
        n_src1  = q_src1;
        n_src2  = q_src2;
        n_dest  = q_dest;
        for (int j = 0; j < IQ_SIZE; j++) begin
            if (keep[j]) begin
                n_valid[dst[j]] = 1'b1;
                n_rdy1[dst[j]]  = q_rdy1[j] || wake1[j];
                n_rdy2[dst[j]]  = q_rdy2[j] || wake2[j];
                n_rf_we[dst[j]] = q_rf_we[j];
                n_op[dst[j]]    = q_op[j];
                n_pc[dst[j]]    = q_pc[j];
                n_rob[dst[j]]   = q_rob[j];
                n_src1[dst[j]]  = q_src1[j];
                n_src2[dst[j]]  = q_src2[j];
                n_dest[dst[j]]  = q_dest[j];
            end
        end
        // new slots land right above the survivors, unwoken
        tail = q_cnt - IQ_CNT_W'(sel1_valid) - IQ_CNT_W'(sel2_valid);
        if (allowin && disp1_valid) begin
            n_valid[tail[IQ_IDX_W-1:0]] = 1'b1;
            n_rdy1[tail[IQ_IDX_W-1:0]]  = disp1_src1_ready;
            n_rdy2[tail[IQ_IDX_W-1:0]]  = disp1_src2_ready;
            n_rf_we[tail[IQ_IDX_W-1:0]] = disp1_rf_we;
            n_op[tail[IQ_IDX_W-1:0]]    = disp1_op;
            n_pc[tail[IQ_IDX_W-1:0]]    = disp1_pc;
            n_rob[tail[IQ_IDX_W-1:0]]   = disp1_rob;
            n_src1[tail[IQ_IDX_W-1:0]]  = disp1_src1;
            n_src2[tail[IQ_IDX_W-1:0]]  = disp1_src2;
            n_dest[tail[IQ_IDX_W-1:0]]  = disp1_dest;
            tail = tail + 1'b1;
        end
        if (allowin && disp2_valid) begin
            n_valid[tail[IQ_IDX_W-1:0]] = 1'b1;
            n_rdy1[tail[IQ_IDX_W-1:0]]  = disp2_src1_ready;
            n_rdy2[tail[IQ_IDX_W-1:0]]  = disp2_src2_ready;
            n_rf_we[tail[IQ_IDX_W-1:0]] = disp2_rf_we;
            n_op[tail[IQ_IDX_W-1:0]]    = disp2_op;
            n_pc[tail[IQ_IDX_W-1:0]]    = disp2_pc;
            n_rob[tail[IQ_IDX_W-1:0]]   = disp2_rob;
            n_src1[tail[IQ_IDX_W-1:0]]  = disp2_src1;
            n_src2[tail[IQ_IDX_W-1:0]]  = disp2_src2;
            n_dest[tail[IQ_IDX_W-1:0]]  = disp2_dest;
            tail = tail + 1'b1;
        end
        n_cnt = tail;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q_valid <= '0;
            q_cnt   <= '0;
        end else if (flush) begin
            q_valid <= '0;
            q_cnt   <= '0;
        end else begin
            q_valid <= n_valid;
            q_cnt   <= n_cnt;
        end
    end

    always_ff @(posedge clk) begin
        q_rdy1  <= n_rdy1;
        q_rdy2  <= n_rdy2;
        q_rf_we <= n_rf_we;
        q_op    <= n_op;
        q_pc    <= n_pc;
        q_rob   <= n_rob;
        q_src1  <= n_src1;
        q_src2  <= n_src2;
        q_dest  <= n_dest;
    end

    assign ent_valid     = q_valid;
    assign ent_src_ready = q_rdy1 & q_rdy2;
    assign ent_op        = q_op;
    assign ent_dest      = q_dest;
    assign ent_rf_we     = q_rf_we;

    assign pick1_pc    = q_pc[sel1_idx];
    assign pick1_rob   = q_rob[sel1_idx];
    assign pick1_op    = q_op[sel1_idx];
    assign pick1_dest  = q_dest[sel1_idx];
    assign pick1_rf_we = q_rf_we[sel1_idx];
    assign pick1_src1  = q_src1[sel1_idx];
    assign pick1_src2  = q_src2[sel1_idx];
    assign pick2_pc    = q_pc[sel2_idx];
    assign pick2_rob   = q_rob[sel2_idx];
    assign pick2_op    = q_op[sel2_idx];
    assign pick2_dest  = q_dest[sel2_idx];
    assign pick2_rf_we = q_rf_we[sel2_idx];
    assign pick2_src1  = q_src1[sel2_idx];
    assign pick2_src2  = q_src2[sel2_idx];

endmodule

`default_nettype wire

// ==== verilog/issue_select.sv ====
`timescale 1ns/10ps
`default_nettype none

module issue_select
    import issue_pkg::*;
(
    input  logic [IQ_SIZE-1:0]   ent_valid,
    input  logic [IQ_SIZE-1:0]   ent_src_ready,
    input  iq_op_e [IQ_SIZE-1:0] ent_op,
    input  preg_t [IQ_SIZE-1:0]  ent_dest,
    input  logic [IQ_SIZE-1:0]   ent_rf_we,
    output logic                 sel1_valid,
    output logic                 sel2_valid,
    output logic [IQ_IDX_W-1:0]  sel1_idx,
    output logic [IQ_IDX_W-1:0]  sel2_idx,
    output preg_t                sel1_dest,
    output preg_t                sel2_dest
);

    logic [IQ_SIZE-1:0] req1, req2;

    // lowest requesting index is the oldest, msb flags a hit
    function automatic logic [IQ_IDX_W:0] oldest(logic [IQ_SIZE-1:0] req);
        logic [IQ_IDX_W:0] res;
        res = '0;
        for (int i = IQ_SIZE - 1; i >= 0; i--) begin
            if (req[i]) begin
                res = {1'b1, IQ_IDX_W'(i)};
            end
        end
        return res;
    endfunction

    always_comb begin
        for (int i = 0; i < IQ_SIZE; i++) begin
            req1[i] = ent_valid[i] && ent_src_ready[i]
                   && (ent_op[i] == op_alu1 || ent_op[i] == op_branch);
            req2[i] = ent_valid[i] && ent_src_ready[i]
                   && (ent_op[i] == op_alu2 || ent_op[i] == op_sp);
        end
    end

    assign {sel1_valid, sel1_idx} = oldest(req1);
    assign {sel2_valid, sel2_idx} = oldest(req2);

    // special ops have long latency and only wake at writeback
    assign sel1_dest = (sel1_valid && ent_rf_we[sel1_idx]) ? ent_dest[sel1_idx] : '0;
    assign sel2_dest = (sel2_valid && ent_rf_we[sel2_idx] && ent_op[sel2_idx] != op_sp)
                     ? ent_dest[sel2_idx] : '0;

endmodule

`default_nettype wire

// ==== verilog/operand_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module operand_stage
    import issue_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n,
    input  logic   flush,
    input  logic   sel1_valid,
    input  logic   sel2_valid,
    input  word_t  pick1_pc,
    input  rob_t   pick1_rob,
    input  iq_op_e pick1_op,
    input  preg_t  pick1_dest,
    input  logic   pick1_rf_we,
    input  preg_t  pick1_src1,
    input  preg_t  pick1_src2,
    input  word_t  pick2_pc,
    input  rob_t   pick2_rob,
    input  iq_op_e pick2_op,
    input  preg_t  pick2_dest,
    input  logic   pick2_rf_we,
    input  preg_t  pick2_src1,
    input  preg_t  pick2_src2,
    input  logic   wb1_we,
    input  preg_t  wb1_dest,
    input  word_t  wb1_result,
    input  logic   wb2_we,
    input  preg_t  wb2_dest,
    input  word_t  wb2_result,
    input  logic   byp1_we,
    input  preg_t  byp1_dest,
    input  word_t  byp1_result,
    input  logic   byp2_we,
    input  preg_t  byp2_dest,
    input  word_t  byp2_result,
    output logic   exe1_valid,
    output iq_op_e exe1_op,
    output word_t  exe1_pc,
    output rob_t   exe1_rob,
    output preg_t  exe1_dest,
    output logic   exe1_rf_we,
    output word_t  exe1_src1_value,
    output word_t  exe1_src2_value,
    output logic   exe2_valid,
    output iq_op_e exe2_op,
    output word_t  exe2_pc,
    output rob_t   exe2_rob,
    output preg_t  exe2_dest,
    output logic   exe2_rf_we,
    output word_t  exe2_src1_value,
    output word_t  exe2_src2_value
);

    preg_t iss1_src1, iss1_src2, iss2_src1, iss2_src2;
    word_t rf1_src1, rf1_src2, rf2_src1, rf2_src2;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exe1_valid <= 1'b0;
            exe2_valid <= 1'b0;
        end else begin
            exe1_valid <= sel1_valid && !flush;
            exe2_valid <= sel2_valid && !flush;
        end
    end

    always_ff @(posedge clk) begin
        exe1_op    <= pick1_op;
        exe1_pc    <= pick1_pc;
        exe1_rob   <= pick1_rob;
        exe1_dest  <= pick1_dest;
        exe1_rf_we <= pick1_rf_we;
        iss1_src1  <= pick1_src1;
        iss1_src2  <= pick1_src2;
        exe2_op    <= pick2_op;
        exe2_pc    <= pick2_pc;
        exe2_rob   <= pick2_rob;
        exe2_dest  <= pick2_dest;
        exe2_rf_we <= pick2_rf_we;
        iss2_src1  <= pick2_src1;
        iss2_src2  <= pick2_src2;
    end

    phys_regfile u_regfile (
        .clk      (clk),
        .rd_addr1 (iss1_src1),
        .rd_addr2 (iss1_src2),
        .rd_addr3 (iss2_src1),
        .rd_addr4 (iss2_src2),
        .rd_data1 (rf1_src1),
        .rd_data2 (rf1_src2),
        .rd_data3 (rf2_src1),
        .rd_data4 (rf2_src2),
        .wr_en1   (wb1_we),
        .wr_en2   (wb2_we),
        .wr_addr1 (wb1_dest),
        .wr_addr2 (wb2_dest),
        .wr_data1 (wb1_result),
        .wr_data2 (wb2_result)
    );

    // bypass beats writeback; wb2 first to agree with the regfile write order
    function automatic word_t fwd(preg_t src, word_t rf_val);
        if (src == '0) return '0;
        if (byp1_we && byp1_dest == src) return byp1_result;
        if (byp2_we && byp2_dest == src) return byp2_result;
        if (wb2_we && wb2_dest == src) return wb2_result;
        if (wb1_we && wb1_dest == src) return wb1_result;
        return rf_val;
    endfunction

    always_comb begin
        exe1_src1_value = fwd(iss1_src1, rf1_src1);
        exe1_src2_value = fwd(iss1_src2, rf1_src2);
        exe2_src1_value = fwd(iss2_src1, rf2_src1);
        exe2_src2_value = fwd(iss2_src2, rf2_src2);
    end

endmodule

`default_nettype wire

// ==== verilog/issue_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module issue_stage
    import issue_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n,
    input  logic   flush,
    input  logic   disp1_valid,
    input  iq_op_e disp1_op,
    input  word_t  disp1_pc,
    input  rob_t   disp1_rob,
    input  preg_t  disp1_src1,
    input  preg_t  disp1_src2,
    input  preg_t  disp1_dest,
    input  logic   disp1_rf_we,
    input  logic   disp1_src1_ready,
    input  logic   disp1_src2_ready,
    input  logic   disp2_valid,
    input  iq_op_e disp2_op,
    input  word_t  disp2_pc,
    input  rob_t   disp2_rob,
    input  preg_t  disp2_src1,
    input  preg_t  disp2_src2,
    input  preg_t  disp2_dest,
    input  logic   disp2_rf_we,
    input  logic   disp2_src1_ready,
    input  logic   disp2_src2_ready,
    output logic   allowin,
    input  logic   wb1_we,
    input  preg_t  wb1_dest,
    input  word_t  wb1_result,
    input  logic   wb2_we,
    input  preg_t  wb2_dest,
    input  word_t  wb2_result,
    input  logic   byp1_we,
    input  preg_t  byp1_dest,
    input  word_t  byp1_result,
    input  logic   byp2_we,
    input  preg_t  byp2_dest,
    input  word_t  byp2_result,
    output logic   exe1_valid,
    output iq_op_e exe1_op,
    output word_t  exe1_pc,
    output rob_t   exe1_rob,
    output preg_t  exe1_dest,
    output logic   exe1_rf_we,
    output word_t  exe1_src1_value,
    output word_t  exe1_src2_value,
    output logic   exe2_valid,
    output iq_op_e exe2_op,
    output word_t  exe2_pc,
    output rob_t   exe2_rob,
    output preg_t  exe2_dest,
    output logic   exe2_rf_we,
    output word_t  exe2_src1_value,
    output word_t  exe2_src2_value,
    output preg_t  sel1_dest,
    output preg_t  sel2_dest
);

    logic [IQ_SIZE-1:0]   ent_valid;
    logic [IQ_SIZE-1:0]   ent_src_ready;
    iq_op_e [IQ_SIZE-1:0] ent_op;
    preg_t [IQ_SIZE-1:0]  ent_dest;
    logic [IQ_SIZE-1:0]   ent_rf_we;

    logic                 sel1_valid, sel2_valid;
    logic [IQ_IDX_W-1:0]  sel1_idx, sel2_idx;

    word_t                pick1_pc, pick2_pc;
    rob_t                 pick1_rob, pick2_rob;
    iq_op_e               pick1_op, pick2_op;
    preg_t                pick1_dest, pick2_dest;
    logic                 pick1_rf_we, pick2_rf_we;
    preg_t                pick1_src1, pick2_src1;
    preg_t                pick1_src2, pick2_src2;

    // the issue register doubles as the second wakeup source
    issue_queue u_queue (
        .*,
        .sel1_claim (sel1_dest),
        .sel2_claim (sel2_dest),
        .iss1_valid (exe1_valid),
        .iss2_valid (exe2_valid),
        .iss1_rf_we (exe1_rf_we),
        .iss2_rf_we (exe2_rf_we),
        .iss1_op    (exe1_op),
        .iss2_op    (exe2_op),
        .iss1_dest  (exe1_dest),
        .iss2_dest  (exe2_dest)
    );

    issue_select u_select (.*);

    operand_stage u_operand (.*);

endmodule

`default_nettype wire

// ==== tb/issue_stage_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module issue_stage_checker
    import issue_pkg::*;
(
    input logic               clk,
    input logic               arst_n,
    input logic               flush,
    input logic               allowin,
    input logic [IQ_SIZE-1:0] ent_valid,
    input logic               sel1_valid,
    input logic               sel2_valid,
    input preg_t              sel1_dest,
    input preg_t              sel2_dest,
    input logic               exe1_valid,
    input logic               exe2_valid
);

    int unsigned fail_count = 0;

    // decode must always be able to drop two slots
    assert property (@(posedge clk) disable iff (!arst_n)
        $countones(ent_valid) >= IQ_SIZE - 1 |-> !allowin)
        else begin
            fail_count++;
            $error("allowin high with no room for two entries");
        end

    assert property (@(posedge clk) disable iff (!arst_n)
        flush |=> !exe1_valid && !exe2_valid)
        else begin
            fail_count++;
            $error("exe valid right after a flush");
        end

    // no claim reaches the busy table without a select
    assert property (@(posedge clk) disable iff (!arst_n)
        !sel1_valid |-> sel1_dest == '0)
        else begin
            fail_count++;
            $error("port 1 claims a dest without a select");
        end

    assert property (@(posedge clk) disable iff (!arst_n)
        !sel2_valid |-> sel2_dest == '0)
        else begin
            fail_count++;
            $error("port 2 claims a dest without a select");
        end

endmodule

bind issue_stage issue_stage_checker u_checker (
    .clk        (clk),
    .arst_n     (arst_n),
    .flush      (flush),
    .allowin    (allowin),
    .ent_valid  (ent_valid),
    .sel1_valid (sel1_valid),
    .sel2_valid (sel2_valid),
    .sel1_dest  (sel1_dest),
    .sel2_dest  (sel2_dest),
    .exe1_valid (exe1_valid),
    .exe2_valid (exe2_valid)
);

`default_nettype wire

// ==== tb/issue_stage_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module issue_stage_tb
    import issue_pkg::*;
();

    typedef logic [2+XLEN+ROB_W+2*PREG_W+1+2*XLEN-1:0] rec_t;

    logic   clk;
    logic   arst_n;
    logic   flush;
    logic   disp1_valid, disp2_valid;
    iq_op_e disp1_op, disp2_op;
    word_t  disp1_pc, disp2_pc;
    rob_t   disp1_rob, disp2_rob;
    preg_t  disp1_src1, disp2_src1;
    preg_t  disp1_src2, disp2_src2;
    preg_t  disp1_dest, disp2_dest;
    logic   disp1_rf_we, disp2_rf_we;
    logic   disp1_src1_ready, disp2_src1_ready;
    logic   disp1_src2_ready, disp2_src2_ready;
    logic   allowin;
    logic   wb1_we, wb2_we;
    preg_t  wb1_dest, wb2_dest;
    word_t  wb1_result, wb2_result;
    logic   byp1_we, byp2_we;
    preg_t  byp1_dest, byp2_dest;
    word_t  byp1_result, byp2_result;
    logic   exe1_valid, exe2_valid;
    iq_op_e exe1_op, exe2_op;
    word_t  exe1_pc, exe2_pc;
    rob_t   exe1_rob, exe2_rob;
    preg_t  exe1_dest, exe2_dest;
    logic   exe1_rf_we, exe2_rf_we;
    word_t  exe1_src1_value, exe2_src1_value;
    word_t  exe1_src2_value, exe2_src2_value;
    preg_t  sel1_dest, sel2_dest;

    rec_t   exp1_q[$];
    rec_t   exp2_q[$];
    word_t  shadow [PREG_NUM];
    string  test_name;
    integer seed;

    // execute model, results captured mid-cycle
    logic   nxt1_we = 1'b0;
    logic   nxt2_we = 1'b0;
    preg_t  nxt1_dest = '0;
    preg_t  nxt2_dest = '0;
    word_t  nxt1_res = '0;
    word_t  nxt2_res = '0;

    // busy-table claim of the cycle before an issue
    preg_t  last_sel1 = '0;
    preg_t  last_sel2 = '0;

    issue_stage dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic rec_t pack(iq_op_e op, word_t pc, rob_t rob, preg_t dest, logic we,
                                  preg_t claim, word_t v1, word_t v2);
        return {op, pc, rob, dest, we, claim, v1, v2};
    endfunction

    function automatic word_t pc_of(rob_t rob);
        return 32'h100 + {25'd0, rob, 2'b00};
    endfunction

    function automatic word_t src_val(preg_t s);
        return (s == '0) ? '0 : shadow[s];
    endfunction

    task automatic abort(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic compare(input int port, input rec_t want, input rec_t got);
        assert (got === want)
            else abort($sformatf("Fail %s port %0d: expected %h actual %h",
                                 test_name, port, want, got));
    endtask

    // special ops have no one-cycle result to bypass
    always @(negedge clk) begin
        nxt1_we   = exe1_valid && exe1_rf_we && exe1_op != op_sp;
        nxt1_dest = exe1_dest;
        nxt1_res  = word_t'(exe1_rob) + 32'h1000;
        nxt2_we   = exe2_valid && exe2_rf_we && exe2_op != op_sp;
        nxt2_dest = exe2_dest;
        nxt2_res  = word_t'(exe2_rob) + 32'h1000;
    end

    always @(posedge clk) begin
        #1;
        byp1_we     = nxt1_we;
        byp1_dest   = nxt1_dest;
        byp1_result = nxt1_res;
        byp2_we     = nxt2_we;
        byp2_dest   = nxt2_dest;
        byp2_result = nxt2_res;
    end

    // every issue must match the oldest expectation of its port
    always @(negedge clk) begin
        if (arst_n && exe1_valid) begin
            assert (exp1_q.size() != 0)
                else abort($sformatf("%s: port 1 issued an instruction nobody expected",
                                     test_name));
            if (exp1_q.size() != 0) begin
                compare(1, exp1_q.pop_front(), pack(exe1_op, exe1_pc, exe1_rob, exe1_dest,
                        exe1_rf_we, last_sel1, exe1_src1_value, exe1_src2_value));
            end
        end
        if (arst_n && exe2_valid) begin
            assert (exp2_q.size() != 0)
                else abort($sformatf("%s: port 2 issued an instruction nobody expected",
                                     test_name));
            if (exp2_q.size() != 0) begin
                compare(2, exp2_q.pop_front(), pack(exe2_op, exe2_pc, exe2_rob, exe2_dest,
                        exe2_rf_we, last_sel2, exe2_src1_value, exe2_src2_value));
            end
        end
        last_sel1 = sel1_dest;
        last_sel2 = sel2_dest;
    end

    task automatic set_slot(input int n, input iq_op_e op, input rob_t rob, input preg_t s1,
                            input preg_t s2, input preg_t dest, input logic r1, input logic r2);
        if (n == 1) begin
            disp1_valid      = 1'b1;
            disp1_op         = op;
            disp1_pc         = pc_of(rob);
            disp1_rob        = rob;
            disp1_src1       = s1;
            disp1_src2       = s2;
            disp1_dest       = dest;
            disp1_rf_we      = dest != '0;
            disp1_src1_ready = r1;
            disp1_src2_ready = r2;
        end else begin
            disp2_valid      = 1'b1;
            disp2_op         = op;
            disp2_pc         = pc_of(rob);
            disp2_rob        = rob;
            disp2_src1       = s1;
            disp2_src2       = s2;
            disp2_dest       = dest;
            disp2_rf_we      = dest != '0;
            disp2_src1_ready = r1;
            disp2_src2_ready = r2;
        end
    endtask

    task automatic expect_issue(input iq_op_e op, input rob_t rob, input preg_t dest,
                                input word_t v1, input word_t v2);
        rec_t  r;
        preg_t claim;
        // writers claim their dest, except special ops
        claim = (dest != '0 && op != op_sp) ? dest : '0;
        r = pack(op, pc_of(rob), rob, dest, dest != '0, claim, v1, v2);
        if (op == op_alu1 || op == op_branch) begin
            exp1_q.push_back(r);
        end else begin
            exp2_q.push_back(r);
        end
    endtask

    task automatic ready_slot(input int n, input iq_op_e op, input rob_t rob, input preg_t s1,
                              input preg_t s2, input preg_t dest);
        set_slot(n, op, rob, s1, s2, dest, 1'b1, 1'b1);
        expect_issue(op, rob, dest, src_val(s1), src_val(s2));
    endtask

    task automatic send();
        int cycles;
        cycles = 0;
        while (!allowin) begin
            @(posedge clk);
            #1;
            cycles++;
            assert (cycles < 20) else abort("allowin stayed low while dispatching");
        end
        @(posedge clk);
        #1;
        disp1_valid = 1'b0;
        disp2_valid = 1'b0;
    endtask

    task automatic write_back(input int port, input preg_t dest, input word_t val);
        shadow[dest] = val;
        if (port == 1) begin
            wb1_we     = 1'b1;
            wb1_dest   = dest;
            wb1_result = val;
        end else begin
            wb2_we     = 1'b1;
            wb2_dest   = dest;
            wb2_result = val;
        end
        @(posedge clk);
        #1;
        wb1_we = 1'b0;
        wb2_we = 1'b0;
    endtask

    task automatic wait_issues(input int limit);
        int cycles;
        cycles = 0;
        while (exp1_q.size() != 0 || exp2_q.size() != 0) begin
            @(posedge clk);
            #1;
            cycles++;
            assert (cycles <= limit)
                else abort($sformatf("%s: timed out waiting for an issue", test_name));
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic reset_check();
        test_name = "reset";
        assert (allowin === 1'b1)
            else abort($sformatf("Fail %s: expected allowin 1 actual %b", test_name, allowin));
        assert (exe1_valid === 1'b0 && exe2_valid === 1'b0)
            else abort($sformatf("Fail %s: expected exe valids 00 actual %b%b",
                                 test_name, exe1_valid, exe2_valid));
        for (int r = 1; r <= 8; r++) begin
            write_back(r % 2 + 1, preg_t'(r), $random(seed));
        end
    endtask

    task automatic routing_test();
        test_name = "routing";
        // two port 1 ops side by side, then two port 2 ops side by side
        ready_slot(1, op_alu1, 5'd1, 6'd1, 6'd2, 6'd33);
        ready_slot(2, op_branch, 5'd2, 6'd5, 6'd0, 6'd0);
        send();
        ready_slot(1, op_alu2, 5'd3, 6'd3, 6'd4, 6'd34);
        ready_slot(2, op_sp, 5'd4, 6'd6, 6'd7, 6'd35);
        send();
        ready_slot(1, op_alu2, 5'd5, 6'd8, 6'd1, 6'd36);
        ready_slot(2, op_alu1, 5'd6, 6'd2, 6'd3, 6'd37);
        send();
        wait_issues(20);
    endtask

    task automatic wb_wakeup_test();
        word_t v;
        test_name = "wb_wakeup";
        set_slot(1, op_alu2, 5'd10, 6'd9, 6'd1, 6'd38, 1'b0, 1'b1);
        send();
        idle(5);
        v = $random(seed);
        expect_issue(op_alu2, 5'd10, 6'd38, v, src_val(6'd1));
        write_back(1, 6'd9, v);
        wait_issues(10);
    endtask

    task automatic spec_wakeup_test();
        word_t v;
        test_name = "spec_wakeup";
        ready_slot(1, op_alu1, 5'd11, 6'd2, 6'd3, 6'd41);
        set_slot(2, op_alu1, 5'd12, 6'd41, 6'd4, 6'd42, 1'b0, 1'b1);
        expect_issue(op_alu1, 5'd12, 6'd42, 32'h1000 + 32'd11, src_val(6'd4));
        send();
        wait_issues(10);
        test_name = "sp_wakeup";
        ready_slot(1, op_sp, 5'd13, 6'd5, 6'd6, 6'd43);
        set_slot(2, op_alu1, 5'd14, 6'd43, 6'd0, 6'd44, 1'b0, 1'b1);
        send();
        wait_issues(10);
        idle(6);
        v = $random(seed);
        expect_issue(op_alu1, 5'd14, 6'd44, v, 32'h0);
        write_back(2, 6'd43, v);
        wait_issues(10);
    endtask

    task automatic flush_test();
        test_name = "flush";
        for (int k = 0; k < 3; k++) begin
            set_slot(1, op_alu1, rob_t'(16 + 2 * k), 6'd50, 6'd0, 6'd0, 1'b0, 1'b1);
            set_slot(2, op_alu2, rob_t'(17 + 2 * k), 6'd50, 6'd0, 6'd51, 1'b0, 1'b1);
            send();
            assert (allowin === 1'b1)
                else abort($sformatf("Fail %s: expected allowin 1 actual %b", test_name, allowin));
        end
        set_slot(1, op_branch, 5'd22, 6'd50, 6'd0, 6'd0, 1'b0, 1'b1);
        send();
        assert (allowin === 1'b0)
            else abort($sformatf("Fail %s: expected allowin 0 actual %b", test_name, allowin));
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        assert (allowin === 1'b1)
            else abort($sformatf("Fail %s: expected allowin 1 actual %b", test_name, allowin));
        // would wake every flushed entry if any survived
        write_back(1, 6'd50, $random(seed));
        idle(8);
    endtask

    initial begin
        seed      = 32'hb62c;
        test_name = "init";
        arst_n    = 1'b0;
        flush     = 1'b0;
        set_slot(1, op_alu1, '0, '0, '0, '0, 1'b0, 1'b0);
        set_slot(2, op_alu1, '0, '0, '0, '0, 1'b0, 1'b0);
        disp1_valid = 1'b0;
        disp2_valid = 1'b0;
        wb1_we      = 1'b0;
        wb1_dest    = '0;
        wb1_result  = '0;
        wb2_we      = 1'b0;
        wb2_dest    = '0;
        wb2_result  = '0;
        byp1_we     = 1'b0;
        byp1_dest   = '0;
        byp1_result = '0;
        byp2_we     = 1'b0;
        byp2_dest   = '0;
        byp2_result = '0;
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;
        reset_check();
        routing_test();
        wb_wakeup_test();
        spec_wakeup_test();
        flush_test();
        if (dut.u_checker.fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
verilog/issue_pkg.sv
verilog/phys_regfile.sv
verilog/issue_queue.sv
verilog/issue_select.sv
verilog/operand_stage.sv
verilog/issue_stage.sv
tb/issue_stage_checker.sv
tb/issue_stage_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= issue_stage_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
